// File: logic/fetch_pkg.sv
// --------------------------------------------------------------------
// shared sizes, types and opcodes of the single-issue RV32I fetch path
// no compressed instructions; every fetch returns exactly one word
// --------------------------------------------------------------------
package fetch_pkg;

  // --------------------------------------------------------------------
  // sizes
  // --------------------------------------------------------------------
  // sequential step, 32-bit instructions only
  localparam int unsigned INSTR_BYTES    = 4;
  // direction predictor size, must be a power of two
  localparam int unsigned BHT_ENTRIES    = 16;
  localparam int unsigned BHT_IDX_W      = $clog2(BHT_ENTRIES);
  // fetch queue, power of two so the pointers wrap by themselves
  localparam int unsigned QUEUE_DEPTH    = 4;
  localparam int unsigned QPTR_W         = $clog2(QUEUE_DEPTH);
  // decode buffer slots, also the credit count after reset or flush
  localparam int unsigned DECODE_CREDITS = 4;
  localparam int unsigned CREDIT_W       = $clog2(DECODE_CREDITS + 1);

  // --------------------------------------------------------------------
  // types
  // --------------------------------------------------------------------
  typedef logic [31:0]          pc_t;
  typedef logic [31:0]          instr_t;
  typedef logic [6:0]           opcode_t;
  typedef logic [BHT_IDX_W-1:0] bht_idx_t;
  typedef logic [1:0]           bht_cnt_t;
  typedef logic [QPTR_W-1:0]    qptr_t;
  // occupancy needs one more bit than the pointers
  typedef logic [QPTR_W:0]      qcnt_t;
  typedef logic [CREDIT_W-1:0]  credit_t;

  // --------------------------------------------------------------------
  // encodings
  // --------------------------------------------------------------------
  // major opcodes seen by the scanner
  localparam opcode_t OPCODE_BRANCH = 7'b1100011;
  localparam opcode_t OPCODE_JAL    = 7'b1101111;

  // counter values loaded on the first update of an entry
  localparam bht_cnt_t BHT_WEAK_NOT_TAKEN = 2'b01;
  localparam bht_cnt_t BHT_WEAK_TAKEN     = 2'b10;

endpackage

// File: logic/branch_scan.sv
// --------------------------------------------------------------------
// combinational scan of one RV32I word for conditional branches and jal
// jalr is not recognised and falls through as an ordinary instruction
// --------------------------------------------------------------------
`timescale 1ns/1ps

module branch_scan (
  input  fetch_pkg::instr_t instr_i,
  output logic              is_branch_o,
  output logic              is_jal_o,
  output fetch_pkg::pc_t    imm_o
);

  import fetch_pkg::*;

  opcode_t opcode;
  pc_t     imm_b;
  pc_t     imm_j;

  assign opcode = instr_i[6:0];

  // --------------------------------------------------------------------
  // opcode decode
  // --------------------------------------------------------------------
  // funct3 is not checked, the reserved branch encodings are rare
  // enough to be treated as branches
  assign is_branch_o = (opcode == OPCODE_BRANCH);
  assign is_jal_o    = (opcode == OPCODE_JAL);

  // --------------------------------------------------------------------
  // immediates
  // --------------------------------------------------------------------
  // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};

  // J-type: imm[20|10:1|11|19:12] in 31:12
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // bit 31 of the result is the sign used by the static fallback
  // meaningless for anything that is neither branch nor jal
  assign imm_o = is_jal_o ? imm_j : imm_b;

endmodule

// File: logic/branch_history.sv
// --------------------------------------------------------------------
// direction table of 2-bit saturating counters, indexed by pc[5:2]
// untagged, so aliasing branches share a counter
// a read of an entry written in the same cycle returns the old value
// --------------------------------------------------------------------
`timescale 1ns/1ps

module branch_history (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  fetch_pkg::pc_t lookup_pc_i,
  input  logic           update_valid_i,
  input  fetch_pkg::pc_t update_pc_i,
  input  logic           update_taken_i,
  output logic           predict_valid_o,
  output logic           predict_taken_o
);

  import fetch_pkg::*;

  bht_cnt_t                   cnt_q [BHT_ENTRIES];
  logic     [BHT_ENTRIES-1:0] valid_q;
  bht_idx_t                   lookup_idx;
  bht_idx_t                   update_idx;

  // skip the two alignment bits
  assign lookup_idx = lookup_pc_i[BHT_IDX_W+1:2];
  assign update_idx = update_pc_i[BHT_IDX_W+1:2];

  // --------------------------------------------------------------------
  // lookup
  // --------------------------------------------------------------------
  assign predict_valid_o = valid_q[lookup_idx];
  // upper counter bit is the direction
  assign predict_taken_o = cnt_q[lookup_idx][1];

  // --------------------------------------------------------------------
  // update
  // --------------------------------------------------------------------
  // valid bits are the only state that must come up known
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (update_valid_i) begin
      valid_q[update_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_valid_i) begin
      if (!valid_q[update_idx]) begin
        // first outcome seeds a weak counter in its own direction
        cnt_q[update_idx] <= update_taken_i ? BHT_WEAK_TAKEN : BHT_WEAK_NOT_TAKEN;
      end else if (update_taken_i) begin
        // saturate at strongly taken
        if (cnt_q[update_idx] != 2'b11) begin
          cnt_q[update_idx] <= cnt_q[update_idx] + bht_cnt_t'(1);
        end
      end else if (cnt_q[update_idx] != 2'b00) begin
        cnt_q[update_idx] <= cnt_q[update_idx] - bht_cnt_t'(1);
      end
    end
  end

endmodule

// File: logic/pc_select.sv
// --------------------------------------------------------------------
// next-pc register and fetch address select
// prediction steers the current request and redirects steer the next one
// the response of a request issued in a redirect cycle is killed
// --------------------------------------------------------------------
`timescale 1ns/1ps

module pc_select (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  fetch_pkg::pc_t boot_addr_i,
  input  logic           fetch_room_i,
  input  logic           predict_valid_i,
  input  fetch_pkg::pc_t predict_target_i,
  input  logic           mispredict_i,
  input  fetch_pkg::pc_t mispredict_target_i,
  input  logic           trap_valid_i,
  input  fetch_pkg::pc_t trap_vector_i,
  output logic           fetch_req_o,
  output fetch_pkg::pc_t fetch_addr_o,
  output logic           resp_kill_o
);

  import fetch_pkg::*;

  pc_t  npc_q;
  pc_t  npc_d;
  pc_t  fetch_addr;
  // first cycle out of reset fetches from the boot address
  logic boot_load_q;
  logic kill_q;

  // the queue reservation is the only limit since memory never stalls
  assign fetch_req_o = fetch_room_i;

  // --------------------------------------------------------------------
  // next pc with the lowest priority first
  // --------------------------------------------------------------------
  always_comb begin
    fetch_addr = boot_load_q ? boot_addr_i : npc_q;
    // predicted redirect takes effect on this very request
    if (predict_valid_i) begin
      fetch_addr = predict_target_i;
    end
    // hold the address while there is no room
    npc_d = fetch_addr;
    if (fetch_req_o) begin
      npc_d = fetch_addr + pc_t'(INSTR_BYTES);
    end
    // trap wins over mispredict among the back-end redirects
    if (mispredict_i) begin
      npc_d = mispredict_target_i;
    end
    if (trap_valid_i) begin
      npc_d = trap_vector_i;
    end
  end

  assign fetch_addr_o = fetch_addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      npc_q       <= '0;
      boot_load_q <= 1'b1;
      // anything answered for a request seen during reset is dropped
      kill_q      <= 1'b1;
    end else begin
      npc_q       <= npc_d;
      boot_load_q <= 1'b0;
      // the request issued now still follows the old path
      kill_q      <= (mispredict_i | trap_valid_i) & fetch_req_o;
    end
  end

  assign resp_kill_o = kill_q;

endmodule

// File: logic/fetch_queue.sv
// --------------------------------------------------------------------
// fetch queue toward decode with credit flow control
// a slot is reserved when a request goes out, so a response always fits
// an entry pushed at an edge can leave in the cycle after it
// --------------------------------------------------------------------
`timescale 1ns/1ps

module fetch_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              fetch_req_i,
  input  logic              resp_valid_i,
  input  fetch_pkg::pc_t    resp_pc_i,
  input  fetch_pkg::instr_t resp_instr_i,
  input  logic              resp_taken_i,
  input  logic              credit_i,
  output logic              fetch_room_o,
  output logic              entry_valid_o,
  output fetch_pkg::pc_t    entry_pc_o,
  output fetch_pkg::instr_t entry_instr_o,
  output logic              entry_taken_o
);

  import fetch_pkg::*;

  // payload storage
  pc_t     pc_mem    [QUEUE_DEPTH];
  instr_t  instr_mem [QUEUE_DEPTH];
  logic    taken_mem [QUEUE_DEPTH];

  qptr_t   wr_ptr_q;
  qptr_t   rd_ptr_q;
  qcnt_t   count_q;
  qcnt_t   count_d;
  qcnt_t   occupancy;
  // one request in flight at most
  logic    reserved_q;
  credit_t credit_q;
  credit_t credit_d;
  logic    push;
  logic    pop;

  // --------------------------------------------------------------------
  // reservation
  // --------------------------------------------------------------------
  assign occupancy    = count_q + qcnt_t'(reserved_q);
  assign fetch_room_o = occupancy < qcnt_t'(QUEUE_DEPTH);

  // --------------------------------------------------------------------
  // push and pop
  // --------------------------------------------------------------------
  assign push = resp_valid_i & ~flush_i;
  // send only while decode has a free slot
  assign pop  = (count_q != '0) & (credit_q != '0);

  assign entry_valid_o = pop;
  assign entry_pc_o    = pc_mem[rd_ptr_q];
  assign entry_instr_o = instr_mem[rd_ptr_q];
  assign entry_taken_o = taken_mem[rd_ptr_q];

  always_comb begin
    count_d = count_q;
    if (push && !pop) begin
      count_d = count_q + qcnt_t'(1);
    end else if (pop && !push) begin
      count_d = count_q - qcnt_t'(1);
    end
    credit_d = credit_q;
    if (pop) begin
      credit_d = credit_d - credit_t'(1);
    end
    if (credit_i) begin
      credit_d = credit_d + credit_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      pc_mem[wr_ptr_q]    <= resp_pc_i;
      instr_mem[wr_ptr_q] <= resp_instr_i;
      taken_mem[wr_ptr_q] <= resp_taken_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      reserved_q <= 1'b0;
      credit_q   <= credit_t'(DECODE_CREDITS);
    end else begin
      reserved_q <= fetch_req_i;
      if (flush_i) begin
        // decode drops its buffer at the same edge
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
        credit_q <= credit_t'(DECODE_CREDITS);
      end else begin
        if (push) begin
          wr_ptr_q <= wr_ptr_q + qptr_t'(1);
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + qptr_t'(1);
        end
        count_q  <= count_d;
        credit_q <= credit_d;
      end
    end
  end

  // reservation upstream keeps a response from landing on a full queue
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> (count_q < qcnt_t'(QUEUE_DEPTH)));

  // decode never returns more slots than it has
  a_credit_max : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= credit_t'(DECODE_CREDITS));

endmodule

// File: logic/fetch_frontend.sv
// --------------------------------------------------------------------
// single-issue RV32I fetch front end, fixed one-cycle memory response
// predicts branches and jal only, jalr is fetched sequentially
// a trap flushes the queue itself, a mispredict relies on flush_i
// --------------------------------------------------------------------
`timescale 1ns/1ps

module fetch_frontend (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  fetch_pkg::pc_t    boot_addr_i,
  input  logic              flush_i,
  // instruction memory
  output logic              fetch_req_o,
  output fetch_pkg::pc_t    fetch_addr_o,
  input  logic              fetch_valid_i,
  input  fetch_pkg::instr_t fetch_data_i,
  // resolved branches from execute
  input  logic              resolve_valid_i,
  input  fetch_pkg::pc_t    resolve_pc_i,
  input  logic              resolve_taken_i,
  input  logic              resolve_mispredict_i,
  input  fetch_pkg::pc_t    resolve_target_i,
  // trap redirect
  input  logic              trap_valid_i,
  input  fetch_pkg::pc_t    trap_vector_i,
  // decode
  output logic              entry_valid_o,
  output fetch_pkg::pc_t    entry_pc_o,
  output fetch_pkg::instr_t entry_instr_o,
  output logic              entry_taken_o,
  input  logic              credit_i
);

  import fetch_pkg::*;

  // address of the previous request, i.e. of the current response
  pc_t  resp_pc_q;
  pc_t  imm;
  pc_t  predict_target;
  logic resp_kill;
  logic resp_ok;
  logic is_branch;
  logic is_jal;
  logic bht_valid;
  logic bht_taken;
  logic predict_taken;
  logic mispredict;
  logic fetch_room;

  always_ff @(posedge clk_i) begin
    if (fetch_req_o) begin
      resp_pc_q <= fetch_addr_o;
    end
  end

  assign mispredict = resolve_valid_i & resolve_mispredict_i;
  // killed responses belong to an abandoned path
  assign resp_ok    = fetch_valid_i & ~resp_kill;

  branch_scan i_branch_scan (
    .instr_i     (fetch_data_i),
    .is_branch_o (is_branch),
    .is_jal_o    (is_jal),
    .imm_o       (imm)
  );

  // every resolve is a conditional branch, so all of them train
  branch_history i_branch_history (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lookup_pc_i     (resp_pc_q),
    .update_valid_i  (resolve_valid_i),
    .update_pc_i     (resolve_pc_i),
    .update_taken_i  (resolve_taken_i),
    .predict_valid_o (bht_valid),
    .predict_taken_o (bht_taken)
  );

  // --------------------------------------------------------------------
  // prediction
  // --------------------------------------------------------------------
  // jal always taken; branch uses the table, else backward means taken
  assign predict_taken  = is_jal | (is_branch & (bht_valid ? bht_taken : imm[31]));
  assign predict_target = resp_pc_q + imm;

  pc_select i_pc_select (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr_i),
    .fetch_room_i        (fetch_room),
    .predict_valid_i     (resp_ok & predict_taken),
    .predict_target_i    (predict_target),
    .mispredict_i        (mispredict),
    .mispredict_target_i (resolve_target_i),
    .trap_valid_i        (trap_valid_i),
    .trap_vector_i       (trap_vector_i),
    .fetch_req_o         (fetch_req_o),
    .fetch_addr_o        (fetch_addr_o),
    .resp_kill_o         (resp_kill)
  );

  // a response arriving with a redirect is old path as well
  fetch_queue i_fetch_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i | trap_valid_i),
    .fetch_req_i   (fetch_req_o),
    .resp_valid_i  (resp_ok & ~(mispredict | trap_valid_i)),
    .resp_pc_i     (resp_pc_q),
    .resp_instr_i  (fetch_data_i),
    .resp_taken_i  (predict_taken),
    .credit_i      (credit_i),
    .fetch_room_o  (fetch_room),
    .entry_valid_o (entry_valid_o),
    .entry_pc_o    (entry_pc_o),
    .entry_instr_o (entry_instr_o),
    .entry_taken_o (entry_taken_o)
  );

endmodule

// File: dv/tb_fetch_frontend.sv
// ----------------------------------------------------------------------
// random-program regression; memory and decode are modelled here
// every resolve is a mispredict paired with a flush, like every trap
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_fetch_frontend;

  import fetch_pkg::*;

  // ----------------------------------------------------------------------
  // run length and program layout
  // ----------------------------------------------------------------------
  localparam int          NUM_ENTRIES   = 2000;
  localparam int          MAX_CYCLES    = NUM_ENTRIES * 20;
  // entries checked before any redirect is issued
  localparam int          QUIET_ENTRIES = 300;
  // program window of 1 KB, addresses outside alias into it
  localparam int          MEM_WORDS     = 256;
  localparam logic [31:0] BOOT_ADDR     = 32'h0000_1000;
  // fixed forward branch used by the training phase
  localparam int          TRAIN_SLOT    = 128;
  localparam logic [31:0] TRAIN_PC      = BOOT_ADDR + 32'h200;
  localparam logic [1:0]  KIND_PLAIN    = 2'd0;
  localparam logic [1:0]  KIND_BRANCH   = 2'd1;
  localparam logic [1:0]  KIND_JAL      = 2'd2;

  logic        clk_i;
  logic        rst_ni;
  pc_t         boot_addr_i;
  logic        flush_i;
  logic        fetch_req_o;
  pc_t         fetch_addr_o;
  logic        fetch_valid_i;
  instr_t      fetch_data_i;
  logic        resolve_valid_i;
  pc_t         resolve_pc_i;
  logic        resolve_taken_i;
  logic        resolve_mispredict_i;
  pc_t         resolve_target_i;
  logic        trap_valid_i;
  pc_t         trap_vector_i;
  logic        entry_valid_o;
  pc_t         entry_pc_o;
  instr_t      entry_instr_o;
  logic        entry_taken_o;
  logic        credit_i;

  // program image, with kind and immediate kept beside each word
  logic [31:0] mem_tbl  [MEM_WORDS];
  logic [1:0]  kind_tbl [MEM_WORDS];
  logic [31:0] imm_tbl  [MEM_WORDS];
  // reference copy of the direction table
  logic [1:0]  model_cnt [16];
  logic [15:0] model_valid;
  logic [31:0] model_pc;
  // memory response for the next cycle
  logic        resp_valid_nxt;
  logic [31:0] resp_data_nxt;
  // redirect to apply in the next cycle
  logic        ev_resolve;
  logic        ev_taken;
  logic        ev_trap;
  logic [31:0] ev_res_pc;
  logic [31:0] ev_target;
  logic [31:0] ev_vector;
  logic        last_taken;
  int          seed;
  int          error_count;
  int          entries_seen;
  int          cycle_count;
  // slots held in decode, and cycles until the next slot frees
  int          decode_used;
  int          release_wait;

  fetch_frontend dut (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .boot_addr_i          (boot_addr_i),
    .flush_i              (flush_i),
    .fetch_req_o          (fetch_req_o),
    .fetch_addr_o         (fetch_addr_o),
    .fetch_valid_i        (fetch_valid_i),
    .fetch_data_i         (fetch_data_i),
    .resolve_valid_i      (resolve_valid_i),
    .resolve_pc_i         (resolve_pc_i),
    .resolve_taken_i      (resolve_taken_i),
    .resolve_mispredict_i (resolve_mispredict_i),
    .resolve_target_i     (resolve_target_i),
    .trap_valid_i         (trap_valid_i),
    .trap_vector_i        (trap_vector_i),
    .entry_valid_o        (entry_valid_o),
    .entry_pc_o           (entry_pc_o),
    .entry_instr_o        (entry_instr_o),
    .entry_taken_o        (entry_taken_o),
    .credit_i             (credit_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // program generation
  // ----------------------------------------------------------------------
  // B-type: imm[12|10:5] rs2 rs1 funct3 imm[4:1|11] opcode
  function automatic logic [31:0] encode_branch(input logic [31:0] imm,
                                                input logic [31:0] bits);
    return {imm[12], imm[10:5], bits[24:12], imm[4:1], imm[11], OPCODE_BRANCH};
  endfunction

  // J-type: imm[20|10:1|11|19:12] rd opcode
  function automatic logic [31:0] encode_jal(input logic [31:0] imm,
                                             input logic [31:0] bits);
    return {imm[20], imm[10:1], imm[11], imm[19:12], bits[11:7], OPCODE_JAL};
  endfunction

  // 20% branches, 10% jal, the rest alu ops plus a few jalr
  task automatic fill_memory();
    int          r;
    logic [31:0] imm;
    logic [31:0] bits;
    for (int i = 0; i < MEM_WORDS; i++) begin
      r    = $unsigned($random(seed)) % 10;
      bits = $random(seed);
      imm  = 32'((($random(seed) & 15) - 8) * 4);
      if (r < 2) begin
        kind_tbl[i] = KIND_BRANCH;
        imm_tbl[i]  = imm;
        mem_tbl[i]  = encode_branch(imm, bits);
      end else if (r < 3) begin
        // a jal onto itself would stall program order
        if (imm == 32'h0) begin
          imm = 32'd16;
        end
        kind_tbl[i] = KIND_JAL;
        imm_tbl[i]  = imm;
        mem_tbl[i]  = encode_jal(imm, bits);
      end else begin
        kind_tbl[i] = KIND_PLAIN;
        imm_tbl[i]  = 32'h0;
        mem_tbl[i]  = {bits[31:7], (r == 9) ? 7'b1100111 : 7'b0010011};
      end
    end
    kind_tbl[TRAIN_SLOT] = KIND_BRANCH;
    imm_tbl[TRAIN_SLOT]  = 32'd8;
    mem_tbl[TRAIN_SLOT]  = encode_branch(32'd8, 32'h0);
  endtask

  function automatic logic [31:0] random_pc();
    logic [31:0] r;
    r = $random(seed);
    return BOOT_ADDR + {22'b0, r[7:0], 2'b00};
  endfunction

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  // jal taken; branch by counter msb if trained, else backward taken
  function automatic logic predict_taken(input logic [31:0] pc);
    logic [7:0] idx;
    logic [3:0] b;
    idx = pc[9:2];
    b   = pc[5:2];
    if (kind_tbl[idx] == KIND_JAL) begin
      return 1'b1;
    end
    if (kind_tbl[idx] != KIND_BRANCH) begin
      return 1'b0;
    end
    if (model_valid[b]) begin
      return model_cnt[b][1];
    end
    return imm_tbl[idx][31];
  endfunction

  task automatic train_model(input logic [31:0] pc, input logic taken);
    logic [3:0] b;
    b = pc[5:2];
    if (!model_valid[b]) begin
      model_cnt[b]   = taken ? 2'b10 : 2'b01;
      model_valid[b] = 1'b1;
    end else if (taken && model_cnt[b] != 2'b11) begin
      model_cnt[b] = model_cnt[b] + 2'd1;
    end else if (!taken && model_cnt[b] != 2'b00) begin
      model_cnt[b] = model_cnt[b] - 2'd1;
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_entry();
    logic       exp_taken;
    logic [7:0] idx;
    idx       = model_pc[9:2];
    exp_taken = predict_taken(model_pc);
    compare_value("entry_pc_o", entry_pc_o, model_pc);
    compare_value("entry_instr_o", entry_instr_o, mem_tbl[idx]);
    compare_value("entry_taken_o", 32'(entry_taken_o), 32'(exp_taken));
    last_taken = entry_taken_o;
    model_pc   = exp_taken ? model_pc + imm_tbl[idx] : model_pc + 32'd4;
    entries_seen++;
  endtask

  // ----------------------------------------------------------------------
  // one clock cycle: drive at the falling edge, sample just before rising
  // ----------------------------------------------------------------------
  task automatic step();
    logic flush_now;
    flush_now            = ev_resolve | ev_trap;
    fetch_valid_i        = resp_valid_nxt;
    fetch_data_i         = resp_data_nxt;
    resolve_valid_i      = ev_resolve;
    resolve_mispredict_i = ev_resolve;
    resolve_taken_i      = ev_taken;
    resolve_pc_i         = ev_res_pc;
    resolve_target_i     = ev_target;
    trap_valid_i         = ev_trap;
    trap_vector_i        = ev_vector;
    flush_i              = flush_now;
    credit_i             = 1'b0;
    // decode frees one slot at a time after a random wait
    if (!flush_now && decode_used > 0) begin
      if (release_wait == 0) begin
        credit_i     = 1'b1;
        decode_used  = decode_used - 1;
        release_wait = $random(seed) & 3;
      end else begin
        release_wait = release_wait - 1;
      end
    end
    #1;
    if (flush_now) begin
      // entry sent in a flush cycle is dropped by decode too
      if (ev_resolve) begin
        train_model(ev_res_pc, ev_taken);
      end
      model_pc    = ev_trap ? ev_vector : ev_target;
      decode_used = 0;
    end else if (entry_valid_o) begin
      check_entry();
      decode_used = decode_used + 1;
      if (decode_used > DECODE_CREDITS) begin
        error_count++;
        $display("decode buffer overflow: %0d entries outstanding at %0t",
                 decode_used, $time);
      end
    end
    resp_valid_nxt = fetch_req_o;
    resp_data_nxt  = mem_tbl[fetch_addr_o[9:2]];
    ev_resolve     = 1'b0;
    ev_trap        = 1'b0;
    @(negedge clk_i);
  endtask

  // about one cycle in 32 gets a mispredict, a trap or both
  task automatic pick_event();
    int          kind;
    logic [31:0] bits;
    if (($random(seed) & 31) == 0) begin
      kind       = $random(seed) & 3;
      bits       = $random(seed);
      ev_resolve = (kind != 2);
      ev_trap    = (kind >= 2);
      ev_taken   = bits[0];
      ev_res_pc  = random_pc();
      ev_target  = random_pc();
      ev_vector  = random_pc();
    end
  endtask

  // two resolves one way, each redirecting to the trained branch
  task automatic train_branch(input logic taken);
    int n;
    repeat (2) begin
      ev_resolve = 1'b1;
      ev_taken   = taken;
      ev_res_pc  = TRAIN_PC;
      ev_target  = TRAIN_PC;
      step();
      n = entries_seen;
      while (entries_seen == n) begin
        step();
      end
    end
    // forward branch, so only the counter can make it taken
    compare_value("entry_taken_o", 32'(last_taken), 32'(taken));
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    seed                 = 32411;
    error_count          = 0;
    entries_seen         = 0;
    decode_used          = 0;
    release_wait         = 0;
    last_taken           = 1'b0;
    resp_valid_nxt       = 1'b0;
    resp_data_nxt        = 32'h0;
    ev_resolve           = 1'b0;
    ev_taken             = 1'b0;
    ev_trap              = 1'b0;
    ev_res_pc            = 32'h0;
    ev_target            = 32'h0;
    ev_vector            = 32'h0;
    model_valid          = '0;
    model_pc             = BOOT_ADDR;
    rst_ni               = 1'b0;
    boot_addr_i          = BOOT_ADDR;
    flush_i              = 1'b0;
    fetch_valid_i        = 1'b0;
    fetch_data_i         = 32'h0;
    resolve_valid_i      = 1'b0;
    resolve_pc_i         = 32'h0;
    resolve_taken_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    resolve_target_i     = 32'h0;
    trap_valid_i         = 1'b0;
    trap_vector_i        = 32'h0;
    credit_i             = 1'b0;
    fill_memory();
    repeat (4) @(negedge clk_i);
    compare_value("entry_valid_o", 32'(entry_valid_o), 32'h0);
    rst_ni = 1'b1;
    // boot, static prediction and credit flow
    while (entries_seen < QUIET_ENTRIES) begin
      step();
    end
    // random mispredicts and traps
    while (entries_seen < NUM_ENTRIES) begin
      pick_event();
      step();
    end
    train_branch(1'b1);
    train_branch(1'b0);
    $display("entries checked: %0d, errors: %0d", entries_seen, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // cycle limit for the whole run
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    error_count++;
    $display("timeout: %0d of %0d entries seen after %0d cycles",
             entries_seen, NUM_ENTRIES, cycle_count);
    $display("entries checked: %0d, errors: %0d", entries_seen, error_count);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: fetch_frontend.f
logic/fetch_pkg.sv
logic/branch_scan.sv
logic/branch_history.sv
logic/pc_select.sv
logic/fetch_queue.sv
logic/fetch_frontend.sv
dv/tb_fetch_frontend.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch front end regression with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_fetch_frontend \
  -f fetch_frontend.f -o sim_fetch_frontend
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_fetch_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi
exit 0
